// ==== hdl/flight_pkg.sv ====
`default_nettype none

package flight_pkg;

    // Microsecond time base, 38 MHz system clock
    localparam int CLKS_PER_US = 38;
    localparam int US_DIV_W    = 6;

    // Receiver pulse decoding
    // 1000 us is stick value 0, each step is 4 us
    localparam int RC_PULSE_BASE_US = 1000;
    localparam int RC_US_PER_STEP   = 4;
    // Anything outside this window is treated as a glitch
    localparam int RC_PULSE_MIN_US  = 800;
    localparam int RC_PULSE_MAX_US  = 2200;
    localparam int RC_WIDTH_W       = 12;

    // Stick neutral point for roll, pitch and yaw
    localparam int STICK_CENTER     = 128;
    // Motors stay off below this throttle
    localparam int THROTTLE_ARM_MIN = 8;
    localparam int MOTOR_RATE_MAX   = 250;

    // ESC output framing
    localparam int FRAME_US          = 2500;
    localparam int ESC_PULSE_BASE_US = 1000;
    localparam int ESC_US_PER_STEP   = 4;

    // Stick value from the receiver
    typedef logic [7:0] rc_val_t;

    // Motor rate, 0 to MOTOR_RATE_MAX
    typedef logic [7:0] motor_rate_t;

    // Signed axis correction, wide enough for the full mix sum
    typedef logic signed [9:0] axis_rate_t;

    // Receiver decoder FSM
    typedef enum logic [1:0] {
        RC_WAIT_LOW,
        RC_WAIT_HIGH,
        RC_MEASURE
    } rc_state_e;

endpackage

`default_nettype wire

// ==== hdl/us_tick_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module us_tick_gen (
    input  logic sys_clk,
    input  logic resetn,
    output logic us_tick
);

    import flight_pkg::*;

    // Cycle counter within one microsecond
    logic [US_DIV_W-1:0] div_cnt;

    // Wrap every CLKS_PER_US cycles
    // Tick is registered so it lands exactly CLKS_PER_US cycles after reset
    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            div_cnt <= '0;
            us_tick <= 1'b0;
        end else begin
            if (div_cnt == US_DIV_W'(CLKS_PER_US - 1)) begin
                div_cnt <= '0;
                us_tick <= 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
                us_tick <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rc_pulse_decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module rc_pulse_decoder (
    input  logic              sys_clk,
    input  logic              resetn,
    input  logic              us_tick,
    input  logic              rc_pwm,
    output flight_pkg::rc_val_t rc_val
);

    import flight_pkg::*;

    // Two-flop synchronizer on the receiver pin
    logic rc_meta;
    logic rc_sync;

    rc_state_e rc_state;

    // High time in microseconds
    logic [RC_WIDTH_W-1:0] width_cnt;

    // Conversion of the current width
    logic [RC_WIDTH_W-1:0] width_above;
    logic [RC_WIDTH_W-1:0] width_steps;
    logic                  width_ok;
    rc_val_t               width_val;

    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            rc_meta <= 1'b1;
            rc_sync <= 1'b1;
        end else begin
            rc_meta <= rc_pwm;
            rc_sync <= rc_meta;
        end
    end

    // Offset from the 1000 us base, only meaningful above the base
    assign width_above = width_cnt - RC_WIDTH_W'(RC_PULSE_BASE_US);
    assign width_steps = width_above / RC_WIDTH_W'(RC_US_PER_STEP);

    // Glitch and overlong pulse window
    assign width_ok = (width_cnt >= RC_WIDTH_W'(RC_PULSE_MIN_US)) &&
                      (width_cnt <= RC_WIDTH_W'(RC_PULSE_MAX_US));

    // Short pulses floor at 0, long ones clamp at 255
    always_comb begin
        if (width_cnt < RC_WIDTH_W'(RC_PULSE_BASE_US)) begin
            width_val = '0;
        end else if (width_steps > RC_WIDTH_W'(255)) begin
            width_val = '1;
        end else begin
            width_val = width_steps[7:0];
        end
    end

    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            rc_state  <= RC_WAIT_LOW;
            width_cnt <= '0;
            rc_val    <= '0;
        end else begin
            case (rc_state)
                // Skip a pulse already in progress at reset release
                RC_WAIT_LOW: begin
                    if (!rc_sync) begin
                        rc_state <= RC_WAIT_HIGH;
                    end
                end
                RC_WAIT_HIGH: begin
                    if (rc_sync) begin
                        width_cnt <= '0;
                        rc_state  <= RC_MEASURE;
                    end
                end
                RC_MEASURE: begin
                    if (rc_sync) begin
                        // Saturate so a stuck-high pin cannot wrap into range
                        if (us_tick && (width_cnt != '1)) begin
                            width_cnt <= width_cnt + 1'b1;
                        end
                    end else begin
                        // Falling edge, keep the old value on a bad width
                        if (width_ok) begin
                            rc_val <= width_val;
                        end
                        rc_state <= RC_WAIT_HIGH;
                    end
                end
                default: begin
                    rc_state <= RC_WAIT_LOW;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/motor_mixer.sv ====
`default_nettype none
`timescale 1ns/1ps

module motor_mixer (
    input  logic                    sys_clk,
    input  logic                    resetn,
    input  flight_pkg::rc_val_t     throttle_val,
    input  flight_pkg::rc_val_t     roll_val,
    input  flight_pkg::rc_val_t     pitch_val,
    input  flight_pkg::rc_val_t     yaw_val,
    output flight_pkg::motor_rate_t motor_1_rate,
    output flight_pkg::motor_rate_t motor_2_rate,
    output flight_pkg::motor_rate_t motor_3_rate,
    output flight_pkg::motor_rate_t motor_4_rate
);

    import flight_pkg::*;

    // Stick offsets from neutral
    axis_rate_t roll_diff;
    axis_rate_t pitch_diff;
    axis_rate_t yaw_diff;

    // Halved corrections, -64 to 63
    axis_rate_t roll_corr;
    axis_rate_t pitch_corr;
    axis_rate_t yaw_corr;

    axis_rate_t throttle_ext;
    axis_rate_t m1_sum;
    axis_rate_t m2_sum;
    axis_rate_t m3_sum;
    axis_rate_t m4_sum;
    logic       armed;

    // Limit a signed mix result to the motor range
    function automatic motor_rate_t clamp_rate(input axis_rate_t sum);
        if (sum < 0) begin
            return '0;
        end else if (sum > axis_rate_t'(MOTOR_RATE_MAX)) begin
            return motor_rate_t'(MOTOR_RATE_MAX);
        end else begin
            return sum[7:0];
        end
    endfunction

    assign roll_diff  = axis_rate_t'({2'b00, roll_val}) - axis_rate_t'(STICK_CENTER);
    assign pitch_diff = axis_rate_t'({2'b00, pitch_val}) - axis_rate_t'(STICK_CENTER);
    assign yaw_diff   = axis_rate_t'({2'b00, yaw_val}) - axis_rate_t'(STICK_CENTER);

    assign roll_corr  = roll_diff >>> 1;
    assign pitch_corr = pitch_diff >>> 1;
    assign yaw_corr   = yaw_diff >>> 1;

    assign throttle_ext = axis_rate_t'({2'b00, throttle_val});

    // X-frame mix
    // 1 front left, 2 front right, 3 rear right, 4 rear left
    assign m1_sum = throttle_ext + pitch_corr + roll_corr - yaw_corr;
    assign m2_sum = throttle_ext + pitch_corr - roll_corr + yaw_corr;
    assign m3_sum = throttle_ext - pitch_corr - roll_corr - yaw_corr;
    assign m4_sum = throttle_ext - pitch_corr + roll_corr + yaw_corr;

    assign armed = (throttle_val >= rc_val_t'(THROTTLE_ARM_MIN));

    // One cycle from stick change to rate
    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            motor_1_rate <= '0;
            motor_2_rate <= '0;
            motor_3_rate <= '0;
            motor_4_rate <= '0;
        end else if (!armed) begin
            motor_1_rate <= '0;
            motor_2_rate <= '0;
            motor_3_rate <= '0;
            motor_4_rate <= '0;
        end else begin
            motor_1_rate <= clamp_rate(m1_sum);
            motor_2_rate <= clamp_rate(m2_sum);
            motor_3_rate <= clamp_rate(m3_sum);
            motor_4_rate <= clamp_rate(m4_sum);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/esc_pwm_generator.sv ====
`default_nettype none
`timescale 1ns/1ps

module esc_pwm_generator (
    input  logic                    sys_clk,
    input  logic                    resetn,
    input  logic                    us_tick,
    input  flight_pkg::motor_rate_t motor_1_rate,
    input  flight_pkg::motor_rate_t motor_2_rate,
    input  flight_pkg::motor_rate_t motor_3_rate,
    input  flight_pkg::motor_rate_t motor_4_rate,
    output logic                    motor_1_pwm,
    output logic                    motor_2_pwm,
    output logic                    motor_3_pwm,
    output logic                    motor_4_pwm
);

    import flight_pkg::*;

    // Microsecond position inside the frame
    typedef logic [$clog2(FRAME_US)-1:0] frame_us_t;

    frame_us_t   frame_cnt;
    logic        frame_start;
    motor_rate_t rate_in [4];
    logic [3:0]  pwm_q;

    assign rate_in[0] = motor_1_rate;
    assign rate_in[1] = motor_2_rate;
    assign rate_in[2] = motor_3_rate;
    assign rate_in[3] = motor_4_rate;

    // Shared frame counter, 0 to FRAME_US - 1
    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            frame_cnt <= '0;
        end else if (us_tick) begin
            if (frame_cnt == frame_us_t'(FRAME_US - 1)) begin
                frame_cnt <= '0;
            end else begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    // First tick of each frame
    assign frame_start = us_tick && (frame_cnt == '0);

    for (genvar i = 0; i < 4; i++) begin : gen_motor
        // Pulse end point, latched once per frame
        frame_us_t pulse_end;
        logic      pwm_r;

        always_ff @(posedge sys_clk) begin
            if (frame_start) begin
                pulse_end <= frame_us_t'(ESC_PULSE_BASE_US + ESC_US_PER_STEP * rate_in[i]);
            end
        end

        // High from frame start until the latched width in ticks
        always_ff @(posedge sys_clk or negedge resetn) begin
            if (!resetn) begin
                pwm_r <= 1'b0;
            end else if (frame_start) begin
                pwm_r <= 1'b1;
            end else if (us_tick && (frame_cnt == pulse_end)) begin
                pwm_r <= 1'b0;
            end
        end

        assign pwm_q[i] = pwm_r;
    end

    assign motor_1_pwm = pwm_q[0];
    assign motor_2_pwm = pwm_q[1];
    assign motor_3_pwm = pwm_q[2];
    assign motor_4_pwm = pwm_q[3];

endmodule

`default_nettype wire

// ==== hdl/drone_flight_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module drone_flight_top (
    input  logic sys_clk,
    input  logic resetn,
    input  logic throttle_pwm,
    input  logic roll_pwm,
    input  logic pitch_pwm,
    input  logic yaw_pwm,
    output logic motor_1_pwm,
    output logic motor_2_pwm,
    output logic motor_3_pwm,
    output logic motor_4_pwm
);

    import flight_pkg::*;

    // Reset synchronizer stages
    logic rst_meta;
    logic rst_sync;

    logic us_tick;

    rc_val_t throttle_val;
    rc_val_t roll_val;
    rc_val_t pitch_val;
    rc_val_t yaw_val;

    motor_rate_t motor_1_rate;
    motor_rate_t motor_2_rate;
    motor_rate_t motor_3_rate;
    motor_rate_t motor_4_rate;

    // Asynchronous assert, release two cycles after the pin
    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            rst_meta <= 1'b0;
            rst_sync <= 1'b0;
        end else begin
            rst_meta <= 1'b1;
            rst_sync <= rst_meta;
        end
    end

    us_tick_gen us_tick_gen_inst (
        .sys_clk (sys_clk),
        .resetn  (rst_sync),
        .us_tick (us_tick)
    );

    // One decoder per receiver channel
    rc_pulse_decoder throttle_dec_inst (
        .sys_clk (sys_clk),
        .resetn  (rst_sync),
        .us_tick (us_tick),
        .rc_pwm  (throttle_pwm),
        .rc_val  (throttle_val)
    );

    rc_pulse_decoder roll_dec_inst (
        .sys_clk (sys_clk),
        .resetn  (rst_sync),
        .us_tick (us_tick),
        .rc_pwm  (roll_pwm),
        .rc_val  (roll_val)
    );

    rc_pulse_decoder pitch_dec_inst (
        .sys_clk (sys_clk),
        .resetn  (rst_sync),
        .us_tick (us_tick),
        .rc_pwm  (pitch_pwm),
        .rc_val  (pitch_val)
    );

    rc_pulse_decoder yaw_dec_inst (
        .sys_clk (sys_clk),
        .resetn  (rst_sync),
        .us_tick (us_tick),
        .rc_pwm  (yaw_pwm),
        .rc_val  (yaw_val)
    );

    motor_mixer motor_mixer_inst (
        .sys_clk      (sys_clk),
        .resetn       (rst_sync),
        .throttle_val (throttle_val),
        .roll_val     (roll_val),
        .pitch_val    (pitch_val),
        .yaw_val      (yaw_val),
        .motor_1_rate (motor_1_rate),
        .motor_2_rate (motor_2_rate),
        .motor_3_rate (motor_3_rate),
        .motor_4_rate (motor_4_rate)
    );

    // Rates are picked up at the next frame start
    esc_pwm_generator esc_pwm_generator_inst (
        .sys_clk      (sys_clk),
        .resetn       (rst_sync),
        .us_tick      (us_tick),
        .motor_1_rate (motor_1_rate),
        .motor_2_rate (motor_2_rate),
        .motor_3_rate (motor_3_rate),
        .motor_4_rate (motor_4_rate),
        .motor_1_pwm  (motor_1_pwm),
        .motor_2_pwm  (motor_2_pwm),
        .motor_3_pwm  (motor_3_pwm),
        .motor_4_pwm  (motor_4_pwm)
    );

endmodule

`default_nettype wire

// ==== verif/tb_drone_flight.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_drone_flight;

    import flight_pkg::*;

    // Edge wait spans two frames, the high count one frame
    localparam int EDGE_TIMEOUT  = 2 * FRAME_US * CLKS_PER_US + 1000;
    localparam int HIGH_TIMEOUT  = FRAME_US * CLKS_PER_US;
    // Decoder, mixer and margin after the last receiver pulse
    localparam int SETTLE_CYCLES = 16;

    logic sys_clk;
    logic resetn;
    logic throttle_pwm;
    logic roll_pwm;
    logic pitch_pwm;
    logic yaw_pwm;
    logic motor_1_pwm;
    logic motor_2_pwm;
    logic motor_3_pwm;
    logic motor_4_pwm;

    int          error_count;
    int          timeout_count;
    int          check_count;
    logic [31:0] lcg_state;

    // Stick values last sent to the receiver inputs
    rc_val_t cur_t;
    rc_val_t cur_r;
    rc_val_t cur_p;
    rc_val_t cur_y;

    // Per-motor results of one measured frame
    motor_rate_t meas_rate [4];
    bit          meas_ok [4];

    drone_flight_top drone_flight_top_inst (
        .sys_clk      (sys_clk),
        .resetn       (resetn),
        .throttle_pwm (throttle_pwm),
        .roll_pwm     (roll_pwm),
        .pitch_pwm    (pitch_pwm),
        .yaw_pwm      (yaw_pwm),
        .motor_1_pwm  (motor_1_pwm),
        .motor_2_pwm  (motor_2_pwm),
        .motor_3_pwm  (motor_3_pwm),
        .motor_4_pwm  (motor_4_pwm)
    );

    // 10 ns period
    always begin
        #5 sys_clk = ~sys_clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Upper bits of the LCG are the better distributed ones
    function automatic rc_val_t random_byte();
        return rc_val_t'(lcg_next() >> 16);
    endfunction

    // X-frame mix, motors numbered 1 to 4
    function automatic motor_rate_t expected_rate(input int motor, input rc_val_t t,
            input rc_val_t r, input rc_val_t p, input rc_val_t y);
        int rc;
        int pc;
        int yc;
        int sum;
        if (int'(t) < THROTTLE_ARM_MIN) begin
            return '0;
        end
        // Offset from center, halved toward minus infinity
        rc = (int'(r) - STICK_CENTER) >>> 1;
        pc = (int'(p) - STICK_CENTER) >>> 1;
        yc = (int'(y) - STICK_CENTER) >>> 1;
        case (motor)
            1: sum = int'(t) + pc + rc - yc;
            2: sum = int'(t) + pc - rc + yc;
            3: sum = int'(t) - pc - rc - yc;
            default: sum = int'(t) - pc + rc + yc;
        endcase
        if (sum < 0) begin
            sum = 0;
        end else if (sum > MOTOR_RATE_MAX) begin
            sum = MOTOR_RATE_MAX;
        end
        return motor_rate_t'(sum);
    endfunction

    // Centered in a receiver step so 1 us of slip still decodes to v
    function automatic int stick_width(input rc_val_t v);
        return RC_PULSE_BASE_US + RC_US_PER_STEP * int'(v) + 2;
    endfunction

    function automatic logic motor_pin(input int idx);
        case (idx)
            0: return motor_1_pwm;
            1: return motor_2_pwm;
            2: return motor_3_pwm;
            default: return motor_4_pwm;
        endcase
    endfunction

    task automatic set_rc_pin(input int channel, input logic level);
        case (channel)
            0: throttle_pwm = level;
            1: roll_pwm = level;
            2: pitch_pwm = level;
            default: yaw_pwm = level;
        endcase
    endtask

    // Channel 0 throttle, 1 roll, 2 pitch, 3 yaw
    task automatic drive_rc_pulse(input int channel, input int width_us);
        @(negedge sys_clk);
        set_rc_pin(channel, 1'b1);
        repeat (width_us * CLKS_PER_US) @(negedge sys_clk);
        set_rc_pin(channel, 1'b0);
    endtask

    // All four channels in parallel, then let decoders and mixer settle
    task automatic apply_sticks(input rc_val_t t, input rc_val_t r,
            input rc_val_t p, input rc_val_t y);
        fork
            drive_rc_pulse(0, stick_width(t));
            drive_rc_pulse(1, stick_width(r));
            drive_rc_pulse(2, stick_width(p));
            drive_rc_pulse(3, stick_width(y));
        join
        repeat (SETTLE_CYCLES) @(negedge sys_clk);
        cur_t = t;
        cur_r = r;
        cur_p = p;
        cur_y = y;
    endtask

    task automatic measure_motor(input int idx);
        int   wait_cnt;
        int   high_cnt;
        int   us;
        int   steps;
        logic prev;
        logic now_lvl;
        meas_ok[idx] = 1'b0;
        meas_rate[idx] = '0;
        wait_cnt = 0;
        @(negedge sys_clk);
        prev = motor_pin(idx);
        now_lvl = prev;
        // Rising edge is low then high on two falling clock edges
        while (!(!prev && now_lvl) && wait_cnt < EDGE_TIMEOUT) begin
            @(negedge sys_clk);
            prev = now_lvl;
            now_lvl = motor_pin(idx);
            wait_cnt++;
        end
        if (!(!prev && now_lvl)) begin
            timeout_count++;
            $display("Timeout at %0t: motor %0d pulse never started", $time, idx + 1);
            return;
        end
        high_cnt = 1;
        @(negedge sys_clk);
        while (motor_pin(idx) && high_cnt < HIGH_TIMEOUT) begin
            high_cnt++;
            @(negedge sys_clk);
        end
        if (motor_pin(idx)) begin
            timeout_count++;
            $display("Timeout at %0t: motor %0d pulse never ended", $time, idx + 1);
            return;
        end
        // Cycles to microseconds to rate, rounded
        us = (high_cnt + CLKS_PER_US / 2) / CLKS_PER_US;
        steps = (us - ESC_PULSE_BASE_US + ESC_US_PER_STEP / 2) / ESC_US_PER_STEP;
        if (steps < 0) begin
            steps = 0;
        end else if (steps > 255) begin
            steps = 255;
        end
        meas_rate[idx] = motor_rate_t'(steps);
        meas_ok[idx] = 1'b1;
    endtask

    task automatic check_motor_rate(input string what, input motor_rate_t got,
            input motor_rate_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error at %0t: %s measured rate %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_pin_low(input string what, input logic got);
        check_count++;
        if (got !== 1'b0) begin
            error_count++;
            $display("error at %0t: %s is %b, expected 0", $time, what, got);
        end
    endtask

    // All motors share a frame start, so one frame measures all four
    task automatic measure_all_motors(input string label);
        fork
            measure_motor(0);
            measure_motor(1);
            measure_motor(2);
            measure_motor(3);
        join
        for (int m = 0; m < 4; m++) begin
            if (meas_ok[m]) begin
                check_motor_rate($sformatf("%s motor %0d", label, m + 1), meas_rate[m],
                                 expected_rate(m + 1, cur_t, cur_r, cur_p, cur_y));
            end
        end
    endtask

    task automatic outputs_low(input string label);
        for (int m = 0; m < 4; m++) begin
            check_pin_low($sformatf("%s motor %0d pin", label, m + 1), motor_pin(m));
        end
    endtask

    task automatic reset_and_idle();
        repeat (4) @(negedge sys_clk);
        outputs_low("in reset");
        repeat (4) @(negedge sys_clk);
        resetn = 1'b1;
        // First frame is still CLKS_PER_US cycles away
        @(negedge sys_clk);
        outputs_low("after release");
        measure_all_motors("no receiver signal");
    endtask

    task automatic throttle_and_arming();
        apply_sticks(8'd100, 8'd128, 8'd128, 8'd128);
        measure_all_motors("throttle 100 centered");
        apply_sticks(8'd5, 8'd200, 8'd40, 8'd255);
        measure_all_motors("throttle 5 disarmed");
    endtask

    // Each axis alone, then all together
    task automatic axis_mixing();
        apply_sticks(8'd120, 8'd200, 8'd128, 8'd128);
        measure_all_motors("roll right");
        apply_sticks(8'd120, 8'd128, 8'd60, 8'd128);
        measure_all_motors("pitch back");
        apply_sticks(8'd120, 8'd128, 8'd128, 8'd230);
        measure_all_motors("yaw right");
        apply_sticks(8'd120, 8'd30, 8'd220, 8'd90);
        measure_all_motors("all axes");
    endtask

    task automatic rate_clamping();
        apply_sticks(8'd255, 8'd255, 8'd255, 8'd255);
        measure_all_motors("full throttle full right");
        apply_sticks(8'd255, 8'd0, 8'd0, 8'd0);
        measure_all_motors("full throttle full left");
        apply_sticks(8'd8, 8'd255, 8'd255, 8'd255);
        measure_all_motors("low throttle full right");
    endtask

    // Out-of-window throttle pulses must leave the rates alone
    task automatic glitch_rejection();
        apply_sticks(8'd100, 8'd128, 8'd128, 8'd128);
        measure_all_motors("glitch baseline");
        drive_rc_pulse(0, 500);
        repeat (SETTLE_CYCLES) @(negedge sys_clk);
        measure_all_motors("after 500 us pulse");
        drive_rc_pulse(0, 2400);
        repeat (SETTLE_CYCLES) @(negedge sys_clk);
        measure_all_motors("after 2400 us pulse");
    endtask

    task automatic random_sticks();
        rc_val_t t;
        rc_val_t r;
        rc_val_t p;
        rc_val_t y;
        for (int i = 0; i < 8; i++) begin
            // Throttle kept at or above arming
            t = rc_val_t'(THROTTLE_ARM_MIN + (lcg_next() >> 16) % 248);
            r = random_byte();
            p = random_byte();
            y = random_byte();
            apply_sticks(t, r, p, y);
            measure_all_motors($sformatf("random set %0d", i));
        end
    endtask

    initial begin
        sys_clk = 1'b0;
        resetn = 1'b0;
        throttle_pwm = 1'b0;
        roll_pwm = 1'b0;
        pitch_pwm = 1'b0;
        yaw_pwm = 1'b0;
        error_count = 0;
        timeout_count = 0;
        check_count = 0;
        lcg_state = 32'hcf3f;
        cur_t = '0;
        cur_r = '0;
        cur_p = '0;
        cur_y = '0;

        reset_and_idle();
        throttle_and_arming();
        axis_mixing();
        rate_clamping();
        glitch_rejection();
        random_sticks();

        $display("Checks: %0d, value errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0 && check_count > 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/flight_pkg.sv
hdl/us_tick_gen.sv
hdl/rc_pulse_decoder.sv
hdl/motor_mixer.sv
hdl/esc_pwm_generator.sv
hdl/drone_flight_top.sv
verif/tb_drone_flight.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the flight path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_drone_flight -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Finished with no errors"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
